/* scrub.f */
verilog/scrub_cfg_pkg.sv
verilog/scrub_bus_pkg.sv
verilog/reset_ctrl.sv
verilog/ddr_scrubber.sv
verilog/scrub_status.sv
verilog/scrub_top.sv
bench/scrub_props.sv
bench/scrub_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the scrubber testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module scrub_tb \
   -f scrub.f \
   -o scrub_sim

# A failing run ends in $fatal, so the exit status carries the result
./obj_dir/scrub_sim

/* bench/scrub_tb.sv */
//--------------------------------------------------------------------------
// Scrubber testbench: clock, reset, LFSR stimulus, memory credit model
// and readback checks
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module scrub_tb;

   import scrub_cfg_pkg::*;
   import scrub_bus_pkg::*;

   logic     clk;
   logic     rst_main_n;
   logic     flr_assert;
   word_t    ctl0;
   ch_mask_t mem_ready;
   ch_mask_t mem_credit;
   logic     flr_done;
   word_t    status0;
   word_t    id0;
   word_t    id1;
   mem_wr_t  mem_wr [0:NUM_CH-1];

   // Model state
   logic [15:0] lfsr;
   int          cycle;
   logic        hold_credits;
   ch_mask_t    en_model;
   int          beat_cnt [NUM_CH];
   int          due_q [NUM_CH][$];

   scrub_top dut_i
   (
      .clk        (clk),
      .rst_main_n (rst_main_n),
      .flr_assert (flr_assert),
      .ctl0       (ctl0),
      .mem_ready  (mem_ready),
      .mem_credit (mem_credit),
      .flr_done   (flr_done),
      .status0    (status0),
      .id0        (id0),
      .id1        (id1),
      .mem_wr     (mem_wr)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   //-----------------------------------------------------------------------
   // Random numbers and reporting
   //-----------------------------------------------------------------------
   function int rand_bits(input int n);
      int r;
      r = 0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
         r    = (r << 1) | int'(lfsr[0]);
      end
      return r;
   endfunction

   task automatic stop_run(input string what);
      $display("%s", what);
      $display("Finished with errors");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (exp !== act)
         stop_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic check_addr(input string name, input addr_t exp, input addr_t act);
      if (exp !== act)
         stop_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (exp !== act)
         stop_run($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
   endtask

   //-----------------------------------------------------------------------
   // One cycle: observe beats at the falling edge, then return credits
   //-----------------------------------------------------------------------
   task automatic tick();
      @(negedge clk);
      cycle++;
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
         mem_credit[ch] = 1'b0;
         if (mem_wr[ch].valid)
         begin
            if (!en_model[ch])
               stop_run($sformatf("Beat issued on disabled channel %0d", ch));
            if (beat_cnt[ch] > int'(SCRB_LAST_ADDR))
               stop_run($sformatf("Beat issued after scrub done on channel %0d", ch));
            check_addr("beat address", addr_t'(beat_cnt[ch]), mem_wr[ch].addr);
            beat_cnt[ch]++;
            due_q[ch].push_back(cycle + rand_bits(3));
         end
         if (!hold_credits && due_q[ch].size() > 0 && due_q[ch][0] <= cycle)
         begin
            void'(due_q[ch].pop_front());
            mem_credit[ch] = 1'b1;
         end
      end
   endtask

   task automatic drive_ctl(input logic dbg, input ch_sel_t sel, input ch_mask_t mask);
      word_t w;
      w                    = '0;
      w[DBG_EN_BIT]        = dbg;
      w[DBG_SEL_LSB +: 3]  = sel;
      w[CH_EN_LSB +: NUM_CH] = mask;
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
         // Any change of enable restarts the model from address 0
         if (!mask[ch] || !en_model[ch])
            beat_cnt[ch] = 0;
      end
      en_model = mask;
      ctl0     = w;
   endtask

   function logic model_done(input int ch);
      return en_model[ch] && (beat_cnt[ch] > int'(SCRB_LAST_ADDR));
   endfunction

   // Readback compare, run only while the engines stand still
   task automatic check_readback(input logic dbg, input ch_sel_t sel);
      ch_mask_t done_m;
      word_t    exp;
      addr_t    a;
      int       s;
      for (int ch = 0; ch < NUM_CH; ch++)
         done_m[ch] = model_done(ch);
      if (dbg)
      begin
         exp = {16'h0, 4'h0, 4'hf, done_m, mem_ready};
         for (int ch = 0; ch < NUM_CH; ch++)
         begin
            if (!en_model[ch])
               exp[16 + 4*ch +: 4] = {2'b00, IDLE};
            else if (done_m[ch])
               exp[16 + 4*ch +: 4] = {2'b00, DONE};
            else
               exp[16 + 4*ch +: 4] = {2'b00, RUN};
         end
         s = (sel > 3'd3) ? 0 : int'(sel);
         a = done_m[s] ? SCRB_LAST_ADDR : addr_t'(en_model[s] ? beat_cnt[s] : 0);
         check_word("debug status0", exp, status0);
         check_addr("debug address", a, {id1, id0});
      end
      else
      begin
         check_word("status0", {STATUS_TAG, done_m, mem_ready}, status0);
         check_word("id0", CL_ID0, id0);
         check_word("id1", CL_ID1, id1);
      end
   endtask

   task automatic wait_all_done();
      int n;
      n = 0;
      while (!(&((~en_model) | {model_done(3), model_done(2), model_done(1), model_done(0)})))
      begin
         tick();
         n++;
         if (n > 10000)
            stop_run("Timeout waiting for the scrub to finish");
      end
   endtask

   //-----------------------------------------------------------------------
   // Test sequence
   //-----------------------------------------------------------------------
   initial
   begin
      int       n;
      ch_mask_t mask;
      ch_sel_t  sel;
      lfsr         = 16'd70;
      cycle        = 0;
      hold_credits = 1'b0;
      en_model     = '0;
      rst_main_n   = 1'b0;
      flr_assert   = 1'b0;
      ctl0         = '0;
      mem_ready    = '0;
      mem_credit   = '0;
      for (int ch = 0; ch < NUM_CH; ch++)
         beat_cnt[ch] = 0;

      repeat (3) tick();
      rst_main_n = 1'b1;
      n = 0;
      while (!dut_i.sync_rst_n)
      begin
         tick();
         n++;
         if (n > 50)
            stop_run("Timeout waiting for reset release");
      end
      // Outputs right after reset release
      for (int ch = 0; ch < NUM_CH; ch++)
         check_bit("valid after reset", 1'b0, mem_wr[ch].valid);
      check_bit("flr_done after reset", 1'b0, flr_done);
      check_word("status0 after reset", '0, status0);
      check_word("id0 after reset", '0, id0);
      check_word("id1 after reset", '0, id1);

      // FLR pulse answered two cycles later
      flr_assert = 1'b1;
      for (int k = 1; k <= 6; k++)
      begin
         tick();
         flr_assert = 1'b0;
         check_bit($sformatf("flr_done cycle %0d", k), k == 2, flr_done);
      end

      // Normal scrub on a random subset
      mask = ch_mask_t'(rand_bits(NUM_CH));
      if (mask == '0)
         mask = 4'b0001;
      mem_ready = ch_mask_t'(rand_bits(NUM_CH));
      drive_ctl(1'b0, 3'd0, mask);
      wait_all_done();
      repeat (3) tick();
      check_readback(1'b0, 3'd0);

      // Debug readback mid-scrub with credits frozen
      for (int it = 0; it < 4; it++)
      begin
         drive_ctl(1'b0, 3'd0, '0);
         repeat (3) tick();
         sel = ch_sel_t'(rand_bits(3));
         drive_ctl(1'b1, sel, mask);
         repeat (20 + rand_bits(6)) tick();
         hold_credits = 1'b1;
         repeat (12) tick();
         check_readback(1'b1, sel);
         hold_credits = 1'b0;
      end
      wait_all_done();

      // Drop one enabled channel, then restart it
      n = 0;
      while (!mask[n])
         n++;
      drive_ctl(1'b1, ch_sel_t'(n), mask & ~(ch_mask_t'(1) << n));
      repeat (4) tick();
      check_bit("done cleared", 1'b0, status0[4 + n]);
      check_readback(1'b1, ch_sel_t'(n));
      drive_ctl(1'b1, ch_sel_t'(n), mask);
      wait_all_done();
      repeat (3) tick();
      check_readback(1'b1, ch_sel_t'(n));

      $display("Finished with no errors");
      $finish;
   end

endmodule

`default_nettype wire

/* bench/scrub_props.sv */
//--------------------------------------------------------------------------
// Credit handshake and address step assertions for each scrub engine
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module scrub_props
(
   input  logic                   clk,
   input  logic                   sync_rst_n,
   input  logic                   enable,
   input  logic                   mem_credit,
   input  scrub_cfg_pkg::credit_t credits,
   input  scrub_bus_pkg::mem_wr_t mem_wr
);

   import scrub_cfg_pkg::*;

   // Credits held by the engine, counted from the write port alone
   int avail;

   always_ff @(posedge clk or negedge sync_rst_n)
      if (!sync_rst_n)
         avail <= int'(MEM_CREDITS);
      else
         avail <= avail + int'(mem_credit) - int'(mem_wr.valid);

   // No beat without a credit in hand
   valid_needs_credit: assert property (@(posedge clk) disable iff (!sync_rst_n)
      mem_wr.valid |-> avail > 0)
      else $error("valid asserted with no credit left at the port");

   // Memory never returns more than it took
   credit_limit: assert property (@(posedge clk) disable iff (!sync_rst_n)
      avail <= int'(MEM_CREDITS))
      else $error("credit count above the granted limit");

   // Engine counter follows the beats and returns seen at the port
   credit_count: assert property (@(posedge clk) disable iff (!sync_rst_n)
      credits == credit_t'(avail))
      else $error("engine credit count differs from the port count");

   // Address steps by one for each issued beat
   addr_step: assert property (@(posedge clk) disable iff (!sync_rst_n)
      (mem_wr.valid && mem_wr.addr != SCRB_LAST_ADDR) |=>
         (!enable || mem_wr.addr == $past(mem_wr.addr) + 64'd1))
      else $error("beat address did not advance by one");

endmodule

bind ddr_scrubber scrub_props props_i
(
   .clk        (clk),
   .sync_rst_n (sync_rst_n),
   .enable     (enable),
   .mem_credit (mem_credit),
   .credits    (credits),
   .mem_wr     (mem_wr)
);

`default_nettype wire

/* verilog/scrub_top.sv */
//--------------------------------------------------------------------------
// Scrubber top level: reset control, status readback and one scrub
// engine per memory channel
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module scrub_top
(
   input  logic                    clk,
   input  logic                    rst_main_n,
   input  logic                    flr_assert,
   input  scrub_cfg_pkg::word_t    ctl0,
   input  scrub_cfg_pkg::ch_mask_t mem_ready,
   input  scrub_cfg_pkg::ch_mask_t mem_credit,
   output logic                    flr_done,
   output scrub_cfg_pkg::word_t    status0,
   output scrub_cfg_pkg::word_t    id0,
   output scrub_cfg_pkg::word_t    id1,
   output scrub_bus_pkg::mem_wr_t  mem_wr [0:scrub_cfg_pkg::NUM_CH-1]
);

   import scrub_cfg_pkg::*;
   import scrub_bus_pkg::*;

   logic       sync_rst_n;
   ch_mask_t   enable;
   scrb_stat_t stat [0:NUM_CH-1];

   reset_ctrl reset_ctrl_i
   (
      .clk        (clk),
      .rst_main_n (rst_main_n),
      .flr_assert (flr_assert),
      .sync_rst_n (sync_rst_n),
      .flr_done   (flr_done)
   );

   scrub_status scrub_status_i
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .ctl0       (ctl0),
      .mem_ready  (mem_ready),
      .stat       (stat),
      .enable     (enable),
      .status0    (status0),
      .id0        (id0),
      .id1        (id1)
   );

   //-----------------------------------------------------------------------
   // Scrub engines
   //-----------------------------------------------------------------------
   for (genvar ch = 0; ch < NUM_CH; ch++)
   begin : g_scrb
      ddr_scrubber ddr_scrubber_i
      (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .enable     (enable[ch]),
         .mem_credit (mem_credit[ch]),
         .mem_wr     (mem_wr[ch]),
         .stat       (stat[ch])
      );
   end

endmodule

`default_nettype wire

/* verilog/scrub_status.sv */
//--------------------------------------------------------------------------
// Control-word register, channel enables and status/ID readback
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module scrub_status
(
   input  logic                      clk,
   input  logic                      sync_rst_n,
   input  scrub_cfg_pkg::word_t      ctl0,
   input  scrub_cfg_pkg::ch_mask_t   mem_ready,
   input  scrub_bus_pkg::scrb_stat_t stat [0:scrub_cfg_pkg::NUM_CH-1],
   output scrub_cfg_pkg::ch_mask_t   enable,
   output scrub_cfg_pkg::word_t      status0,
   output scrub_cfg_pkg::word_t      id0,
   output scrub_cfg_pkg::word_t      id1
);

   import scrub_cfg_pkg::*;

   word_t                 ctl_q;
   ch_mask_t              ready_q;
   logic                  dbg_en;
   ch_sel_t               dbg_sel;
   ch_mask_t              done_v;
   logic [4*NUM_CH-1:0]   state_nib;
   addr_t                 sel_addr;

   //-----------------------------------------------------------------------
   // Input registers
   //-----------------------------------------------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
      if (!sync_rst_n)
      begin
         ctl_q   <= '0;
         ready_q <= '0;
      end
      else
      begin
         ctl_q   <= ctl0;
         ready_q <= mem_ready;
      end

   // Control word fields
   assign enable  = ctl_q[CH_EN_LSB +: NUM_CH];
   assign dbg_en  = ctl_q[DBG_EN_BIT];
   assign dbg_sel = ctl_q[DBG_SEL_LSB +: 3];

   //-----------------------------------------------------------------------
   // Gather per-channel status
   //-----------------------------------------------------------------------
   always_comb
   begin
      for (int i = 0; i < NUM_CH; i++)
      begin
         done_v[i]          = stat[i].done;
         // Top two bits of each nibble read as zero
         state_nib[4*i +: 4] = {2'b00, stat[i].state};
      end
   end

   // Debug address mux, out-of-range selects fall back to channel 0
   always_comb
   begin
      sel_addr = stat[0].addr;
      for (int i = 1; i < NUM_CH; i++)
      begin
         if (dbg_sel == ch_sel_t'(i))
            sel_addr = stat[i].addr;
      end
   end

   //-----------------------------------------------------------------------
   // Readback registers
   //-----------------------------------------------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
      if (!sync_rst_n)
      begin
         status0 <= '0;
         id0     <= '0;
         id1     <= '0;
      end
      else if (dbg_en)
      begin
         status0 <= {state_nib, 4'h0, 4'hf, done_v, ready_q};
         id0     <= sel_addr[31:0];
         id1     <= sel_addr[63:32];
      end
      else
      begin
         status0 <= {STATUS_TAG, done_v, ready_q};
         id0     <= CL_ID0;
         id1     <= CL_ID1;
      end

endmodule

`default_nettype wire

/* verilog/ddr_scrubber.sv */
//--------------------------------------------------------------------------
// Single-channel scrub engine: state machine, beat address counter and
// write-port credit counter
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module ddr_scrubber
(
   input  logic                      clk,
   input  logic                      sync_rst_n,
   input  logic                      enable,
   input  logic                      mem_credit,
   output scrub_bus_pkg::mem_wr_t    mem_wr,
   output scrub_bus_pkg::scrb_stat_t stat
);

   import scrub_cfg_pkg::*;
   import scrub_bus_pkg::*;

   scrb_state_e state;
   addr_t       cur_addr;
   credit_t     credits;
   logic        issue;
   logic        last_beat;

   //-----------------------------------------------------------------------
   // Beat issue
   //-----------------------------------------------------------------------
   // One beat per cycle, only while running and holding a credit
   assign issue     = enable && (state == RUN) && (credits != '0);
   assign last_beat = (cur_addr == SCRB_LAST_ADDR);

   //-----------------------------------------------------------------------
   // State machine and address counter
   //-----------------------------------------------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
      if (!sync_rst_n)
      begin
         state    <= IDLE;
         cur_addr <= '0;
      end
      else if (!enable)
      begin
         // Dropping the enable abandons the scrub from any state
         state    <= IDLE;
         cur_addr <= '0;
      end
      else
      begin
         case (state)
            IDLE:
            begin
               state    <= RUN;
               cur_addr <= '0;
            end
            RUN:
            begin
               if (issue)
               begin
                  if (last_beat)
                     state <= DONE;
                  else
                     cur_addr <= cur_addr + 64'd1;
               end
            end
            DONE:
               state <= DONE;
            default:
               state <= IDLE;
         endcase
      end

   //-----------------------------------------------------------------------
   // Credit counter
   //-----------------------------------------------------------------------
   // Credits keep flowing back even after the engine is disabled
   always_ff @(posedge clk or negedge sync_rst_n)
      if (!sync_rst_n)
         credits <= MEM_CREDITS;
      else
      begin
         case ({mem_credit, issue})
            2'b10:
               credits <= credits + 3'd1;
            2'b01:
               credits <= credits - 3'd1;
            default:
               credits <= credits;
         endcase
      end

   //-----------------------------------------------------------------------
   // Outputs
   //-----------------------------------------------------------------------
   always_comb
   begin
      mem_wr.valid = issue;
      mem_wr.addr  = cur_addr;
      stat.state   = state;
      stat.done    = (state == DONE);
      stat.addr    = cur_addr;
   end

endmodule

`default_nettype wire

/* verilog/reset_ctrl.sv */
//--------------------------------------------------------------------------
// Reset synchronizer and FLR acknowledge
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module reset_ctrl
(
   input  logic clk,
   input  logic rst_main_n,
   input  logic flr_assert,
   output logic sync_rst_n,
   output logic flr_done
);

   logic [3:0] rst_pipe;
   logic       pre_sync_rst_n;
   logic       flr_q;

   // Four-stage pipe, cleared at once when the main reset drops
   always_ff @(posedge clk or negedge rst_main_n)
      if (!rst_main_n)
         rst_pipe <= '0;
      else
         rst_pipe <= {rst_pipe[2:0], rst_main_n};

   // Final two flops form the block reset
   always_ff @(posedge clk or negedge rst_pipe[3])
      if (!rst_pipe[3])
      begin
         pre_sync_rst_n <= 1'b0;
         sync_rst_n     <= 1'b0;
      end
      else
      begin
         pre_sync_rst_n <= 1'b1;
         sync_rst_n     <= pre_sync_rst_n;
      end

   // FLR request is registered, done never repeats on back-to-back cycles
   always_ff @(posedge clk or negedge sync_rst_n)
      if (!sync_rst_n)
      begin
         flr_q    <= 1'b0;
         flr_done <= 1'b0;
      end
      else
      begin
         flr_q    <= flr_assert;
         flr_done <= flr_q && !flr_done;
      end

endmodule

`default_nettype wire

/* verilog/scrub_bus_pkg.sv */
//--------------------------------------------------------------------------
// Scrubber bus types: engine state, per-channel status and write beat
//--------------------------------------------------------------------------
`default_nettype none

package scrub_bus_pkg;

   //-----------------------------------------------------------------------
   // Scrub engine state
   //-----------------------------------------------------------------------
   typedef enum logic [1:0]
   {
      IDLE = 2'd0,
      RUN  = 2'd1,
      DONE = 2'd2
   } scrb_state_e;

   //-----------------------------------------------------------------------
   // Per-channel report to the status block
   //-----------------------------------------------------------------------
   typedef struct packed
   {
      scrb_state_e          state;
      logic                 done;
      // Address of the next beat to write
      scrub_cfg_pkg::addr_t addr;
   } scrb_stat_t;

   //-----------------------------------------------------------------------
   // One zero-write beat towards memory
   //-----------------------------------------------------------------------
   typedef struct packed
   {
      logic                 valid;
      scrub_cfg_pkg::addr_t addr;
   } mem_wr_t;

endpackage

`default_nettype wire

/* verilog/scrub_cfg_pkg.sv */
//--------------------------------------------------------------------------
// Scrubber configuration: widths, vector types, limits, ID words and the
// bit positions of the control word
//--------------------------------------------------------------------------
`default_nettype none

package scrub_cfg_pkg;

   // Number of memory channels handled by the block
   localparam int NUM_CH = 4;

   //-----------------------------------------------------------------------
   // Vector types
   //-----------------------------------------------------------------------
   typedef logic [63:0]       addr_t;
   typedef logic [31:0]       word_t;
   typedef logic [NUM_CH-1:0] ch_mask_t;
   typedef logic [2:0]        ch_sel_t;
   typedef logic [2:0]        credit_t;

   //-----------------------------------------------------------------------
   // Scrub engine limits
   //-----------------------------------------------------------------------
   // Credits each memory write port grants after reset
   localparam credit_t MEM_CREDITS = 3'd4;

   // Last beat address written, kept short for simulation
   localparam addr_t SCRB_LAST_ADDR = 64'd255;

   //-----------------------------------------------------------------------
   // Readback constants
   //-----------------------------------------------------------------------
   // Upper field of status0 in normal mode
   localparam logic [23:0] STATUS_TAG = 24'ha1111f;

   // Identification words when debug is off
   localparam word_t CL_ID0 = 32'h5c2b_1d0f;
   localparam word_t CL_ID1 = 32'h0000_a5c4;

   // Control word layout
   localparam int DBG_EN_BIT  = 31;
   localparam int DBG_SEL_LSB = 28;
   localparam int CH_EN_LSB   = 0;

endpackage

`default_nettype wire
